// File: verilog.f
logic/pwo_pkg.sv
logic/pwo_cfg_regs.sv
logic/pwo_ctrl.sv
logic/pwo_lane.sv
logic/pwo_datapath.sv
logic/pwo_top.sv
sim/pwo_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pointwise engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module pwo_top_tb -o pwo_sim

out=$(./obj_dir/pwo_sim)
echo "$out"

echo "$out" | grep -qx "Testbench passed"

// File: sim/pwo_top_tb.sv
`timescale 1ns/1ps

module pwo_top_tb
    import pwo_pkg::*;
();

    localparam int ADDR_W       = 15;
    localparam int MEM_WORDS    = 2 ** ADDR_W;
    localparam int NUM_RUNS     = 6;
    localparam int DONE_TIMEOUT = 200;
    localparam int STRAY_EN_AT  = 20;

    typedef logic [ADDR_W-1:0] addr_t;

    // One run: configuration plus whether c reads are expected
    typedef struct packed {
        pwo_mode_t mode;
        logic      accumulate;
        addr_t     a_base;
        addr_t     b_base;
        addr_t     c_base;
        logic      exp_c_rd;
    } run_row_t;

    logic      clk = 1'b0;
    logic      reset_n;
    logic      enable;
    pwo_mode_t mode;
    logic      accumulate;
    addr_t     a_base_addr;
    addr_t     b_base_addr;
    addr_t     c_base_addr;
    logic      a_rd_en;
    logic      b_rd_en;
    logic      c_rd_en;
    logic      wr_en;
    logic      busy;
    logic      done;
    addr_t     a_rd_addr;
    addr_t     b_rd_addr;
    addr_t     c_rd_addr;
    addr_t     wr_addr;
    mem_word_t a_rd_data = '0;
    mem_word_t b_rd_data = '0;
    mem_word_t c_rd_data = '0;
    mem_word_t wr_data;

    mem_word_t a_mem    [MEM_WORDS];
    mem_word_t b_mem    [MEM_WORDS];
    mem_word_t c_mem    [MEM_WORDS];
    mem_word_t main_mem [MEM_WORDS];

    run_row_t    runs [NUM_RUNS];
    run_row_t    cur;
    logic [31:0] rng_state = 32'h5e67;
    int          word_errs = 0;
    int          addr_errs = 0;
    int          flag_errs = 0;

    // Monitor state
    int cyc = 0;
    int rd_k = 0;
    int wr_k = 0;
    int done_cnt = 0;
    int last_wr_cyc = 0;
    int rd_cyc [POLY_WORDS];

    pwo_top #(
        .MEM_ADDR_WIDTH (ADDR_W)
    ) pwo_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable),
        .mode_i        (mode),
        .accumulate_i  (accumulate),
        .a_base_addr_i (a_base_addr),
        .b_base_addr_i (b_base_addr),
        .c_base_addr_i (c_base_addr),
        .a_rd_en_o     (a_rd_en),
        .a_rd_addr_o   (a_rd_addr),
        .a_rd_data_i   (a_rd_data),
        .b_rd_en_o     (b_rd_en),
        .b_rd_addr_o   (b_rd_addr),
        .b_rd_data_i   (b_rd_data),
        .c_rd_en_o     (c_rd_en),
        .c_rd_addr_o   (c_rd_addr),
        .c_rd_data_i   (c_rd_data),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data),
        .busy_o        (busy),
        .done_o        (done)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Memory models, one cycle read latency
    // ==================================================

    always @(posedge clk) begin
        if (a_rd_en) a_rd_data <= a_mem[a_rd_addr];
        if (b_rd_en) b_rd_data <= b_mem[b_rd_addr];
        if (c_rd_en) c_rd_data <= c_mem[c_rd_addr];
        if (wr_en) main_mem[wr_addr] = wr_data;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic coeff_t next_coeff();
        rng_state = xorshift32(rng_state);
        return coeff_t'(rng_state % 32'(MLDSA_Q));
    endfunction

    // Reference result of one coefficient, wide integer arithmetic
    function automatic coeff_t ref_coeff(input pwo_mode_t m, input logic acc,
                                         input coeff_t a, input coeff_t b, input coeff_t c);
        longint q;
        longint r;
        q = longint'(MLDSA_Q);
        case (m)
            mode_pwm: begin
                r = longint'(a) * longint'(b);
                if (acc) r = r + longint'(c);
            end
            mode_pwa: r = longint'(a) + longint'(b);
            default:  r = longint'(a) - longint'(b) + q;
        endcase
        return coeff_t'(r % q);
    endfunction

    task automatic check_word(input mem_word_t got, input mem_word_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            addr_errs++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("[ERROR] %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ==================================================
    // Strobe, address and timing monitor
    // ==================================================

    always @(negedge clk) begin
        cyc++;
        if (reset_n) begin
            if (!busy && !done && !a_rd_en && !wr_en) begin
                rd_k = 0;
                wr_k = 0;
            end
            check_flag(b_rd_en, a_rd_en, "b read strobe");
            check_flag(c_rd_en, a_rd_en && cur.exp_c_rd, "c read strobe");
            if (a_rd_en) begin
                check_flag(rd_k < POLY_WORDS, 1'b1, "read within 64 words");
                check_flag(busy, 1'b1, "busy during reads");
                check_addr(a_rd_addr, cur.a_base + addr_t'(rd_k), "a read address");
                check_addr(b_rd_addr, cur.b_base + addr_t'(rd_k), "b read address");
                if (c_rd_en) check_addr(c_rd_addr, cur.c_base + addr_t'(rd_k), "c read address");
                if (rd_k < POLY_WORDS) rd_cyc[rd_k] = cyc;
                rd_k++;
            end
            if (wr_en) begin
                check_flag(wr_k < POLY_WORDS, 1'b1, "write within 64 words");
                check_flag(busy, 1'b1, "busy during writes");
                check_addr(wr_addr, cur.c_base + addr_t'(wr_k), "write address");
                if (wr_k < POLY_WORDS)
                    check_flag(cyc - rd_cyc[wr_k] == PW_LATENCY, 1'b1, "read to write latency");
                last_wr_cyc = cyc;
                wr_k++;
            end
            if (done) begin
                done_cnt++;
                check_flag(busy, 1'b0, "busy in done cycle");
                check_flag(rd_k == POLY_WORDS && wr_k == POLY_WORDS, 1'b1, "64 reads and writes");
                check_flag(cyc == last_wr_cyc + 1, 1'b1, "done one cycle after last write");
            end
        end
    end

    initial begin
        int        cycles;
        int        done_before;
        logic      got_done;
        logic      timed_out;
        mem_word_t exp_word;

        reset_n     = 1'b0;
        enable      = 1'b0;
        mode        = mode_pwm;
        accumulate  = 1'b0;
        a_base_addr = '0;
        b_base_addr = '0;
        c_base_addr = '0;
        timed_out   = 1'b0;
        cur         = '0;

        runs[0] = '{mode_pwm, 1'b0, 15'h0000, 15'h0400, 15'h0800, 1'b0};
        runs[1] = '{mode_pwm, 1'b1, 15'h0040, 15'h0440, 15'h0840, 1'b1};
        runs[2] = '{mode_pwa, 1'b0, 15'h1000, 15'h2000, 15'h3000, 1'b0};
        runs[3] = '{mode_pws, 1'b0, 15'h1040, 15'h2040, 15'h3040, 1'b0};
        runs[4] = '{mode_pws, 1'b1, 15'h7f80, 15'h0080, 15'h4000, 1'b0};
        runs[5] = '{mode_pwm, 1'b1, 15'h5000, 15'h5000, 15'h6000, 1'b1};

        // Pad bits set so the DUT must drop them
        for (int addr = 0; addr < MEM_WORDS; addr++) begin
            for (int i = 0; i < LANES; i++) begin
                a_mem[addr][i] = {1'b1, next_coeff()};
                b_mem[addr][i] = {1'b1, next_coeff()};
                c_mem[addr][i] = {1'b1, next_coeff()};
            end
        end
        // Corner values
        a_mem[15'h0000][1] = {1'b1, MLDSA_Q - 23'd1};
        b_mem[15'h0400][1] = {1'b1, MLDSA_Q - 23'd1};
        a_mem[15'h1040][0] = {1'b1, 23'd0};
        b_mem[15'h2040][0] = {1'b1, MLDSA_Q - 23'd1};

        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_flag(a_rd_en || b_rd_en || c_rd_en || wr_en, 1'b0, "strobes after reset");
        check_flag(busy || done, 1'b0, "busy and done after reset");
        check_word(wr_data, '0, "write data after reset");

        for (int r = 0; r < NUM_RUNS && !timed_out; r++) begin
            cur         = runs[r];
            done_before = done_cnt;
            mode        = cur.mode;
            accumulate  = cur.accumulate;
            a_base_addr = cur.a_base;
            b_base_addr = cur.b_base;
            c_base_addr = cur.c_base;
            enable      = 1'b1;
            @(negedge clk);
            enable   = 1'b0;
            check_flag(busy && !a_rd_en, 1'b1, "busy without reads in start cycle");
            // Different inputs from here on, the latched configuration must hold
            mode        = (cur.mode == mode_pwa) ? mode_pws : mode_pwa;
            accumulate  = ~cur.accumulate;
            a_base_addr = ~cur.a_base;
            b_base_addr = ~cur.b_base;
            c_base_addr = ~cur.c_base;
            cycles   = 0;
            got_done = 1'b0;
            // A stray enable mid-run must not start a second run
            while (!got_done && cycles < DONE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
                if (cycles == 1) check_flag(a_rd_en, 1'b1, "first read after start cycle");
                enable   = (cycles >= STRAY_EN_AT) && (cycles < STRAY_EN_AT + 3);
                got_done = done;
            end
            enable = 1'b0;
            if (!got_done) begin
                $display("Timeout: no done_o pulse within %0d cycles in run %0d", cycles, r);
                timed_out = 1'b1;
            end else begin
                repeat (10) @(negedge clk);
                check_flag(done_cnt == done_before + 1, 1'b1, "one done pulse per run");
                for (int k = 0; k < POLY_WORDS; k++) begin
                    for (int i = 0; i < LANES; i++) begin
                        exp_word[i] = {1'b0, ref_coeff(cur.mode, cur.exp_c_rd,
                            a_mem[cur.a_base + addr_t'(k)][i][COEFF_W-1:0],
                            b_mem[cur.b_base + addr_t'(k)][i][COEFF_W-1:0],
                            c_mem[cur.c_base + addr_t'(k)][i][COEFF_W-1:0])};
                    end
                    check_word(main_mem[cur.c_base + addr_t'(k)], exp_word,
                               $sformatf("run %0d word %0d", r, k));
                end
            end
        end

        $display("Errors: data %0d, address %0d, control %0d", word_errs, addr_errs, flag_errs);
        if (!timed_out && word_errs == 0 && addr_errs == 0 && flag_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: logic/pwo_top.sv
`timescale 1ns/1ps

module pwo_top
    import pwo_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 15
)
(
    input  logic                      clk,
    input  logic                      reset_n,

    // Configuration and start
    input  logic                      enable_i,
    input  pwo_mode_t                 mode_i,
    input  logic                      accumulate_i,
    input  logic [MEM_ADDR_WIDTH-1:0] a_base_addr_i,
    input  logic [MEM_ADDR_WIDTH-1:0] b_base_addr_i,
    input  logic [MEM_ADDR_WIDTH-1:0] c_base_addr_i,

    // Read ports, one cycle latency
    output logic                      a_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] a_rd_addr_o,
    input  mem_word_t                 a_rd_data_i,
    output logic                      b_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] b_rd_addr_o,
    input  mem_word_t                 b_rd_data_i,
    output logic                      c_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] c_rd_addr_o,
    input  mem_word_t                 c_rd_data_i,

    // Main memory write port
    output logic                      wr_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] wr_addr_o,
    output mem_word_t                 wr_data_o,

    output logic                      busy_o,
    output logic                      done_o
);

    logic                      start;
    pwo_mode_t                 cfg_mode;
    logic                      cfg_accumulate;
    logic [MEM_ADDR_WIDTH-1:0] cfg_a_base;
    logic [MEM_ADDR_WIDTH-1:0] cfg_b_base;
    logic [MEM_ADDR_WIDTH-1:0] cfg_c_base;
    logic                      acc_sel;

    pwo_cfg_regs #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) pwo_cfg_regs_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .busy_i        (busy_o),
        .mode_i        (mode_i),
        .accumulate_i  (accumulate_i),
        .a_base_addr_i (a_base_addr_i),
        .b_base_addr_i (b_base_addr_i),
        .c_base_addr_i (c_base_addr_i),
        .start_o       (start),
        .mode_o        (cfg_mode),
        .accumulate_o  (cfg_accumulate),
        .a_base_o      (cfg_a_base),
        .b_base_o      (cfg_b_base),
        .c_base_o      (cfg_c_base)
    );

    pwo_ctrl #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) pwo_ctrl_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start),
        .accumulate_i (cfg_accumulate),
        .a_base_i     (cfg_a_base),
        .b_base_i     (cfg_b_base),
        .c_base_i     (cfg_c_base),
        .a_rd_en_o    (a_rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_en_o    (b_rd_en_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .wr_en_o      (wr_en_o),
        .wr_addr_o    (wr_addr_o),
        .acc_sel_o    (acc_sel),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    pwo_datapath pwo_datapath_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .mode_i      (cfg_mode),
        .acc_sel_i   (acc_sel),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .wr_data_o   (wr_data_o)
    );

endmodule

// File: logic/pwo_datapath.sv
`timescale 1ns/1ps

module pwo_datapath
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  pwo_mode_t mode_i,
    input  logic      acc_sel_i,
    input  mem_word_t a_rd_data_i,
    input  mem_word_t b_rd_data_i,
    input  mem_word_t c_rd_data_i,
    output mem_word_t wr_data_o
);

    mem_word_t a_q;
    mem_word_t b_q;
    mem_word_t c_q;
    coeff_t    lane_res [LANES];

    // Memory read data is registered before it enters the lanes
    always_ff @(posedge clk) begin
        a_q <= a_rd_data_i;
        b_q <= b_rd_data_i;
        c_q <= c_rd_data_i;
    end

    // ==================================================
    // Four coefficient lanes
    // ==================================================

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        // Pad bits of the incoming slots are dropped here
        pwo_lane pwo_lane_inst (
            .clk       (clk),
            .reset_n   (reset_n),
            .mode_i    (mode_i),
            .acc_sel_i (acc_sel_i),
            .a_i       (a_q[i][COEFF_W-1:0]),
            .b_i       (b_q[i][COEFF_W-1:0]),
            .c_i       (c_q[i][COEFF_W-1:0]),
            .res_o     (lane_res[i])
        );

        // Zero extension leaves the pad bit cleared
        assign wr_data_o[i] = SLOT_W'(lane_res[i]);
    end

endmodule

// File: logic/pwo_lane.sv
`timescale 1ns/1ps

module pwo_lane
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  pwo_mode_t mode_i,
    input  logic      acc_sel_i,
    input  coeff_t    a_i,
    input  coeff_t    b_i,
    input  coeff_t    c_i,
    output coeff_t    res_o
);

    // 2^23 mod Q, as Q = 2^23 - 2^13 + 1
    localparam logic [13:0] FOLD_K  = 14'd8191;
    localparam int          FOLD1_W = 38;
    localparam int          FOLD2_W = 29;
    localparam int          FOLD3_W = 24;

    logic [PROD_W-1:0]  raw_d;
    logic [PROD_W-1:0]  raw_q;
    logic [FOLD1_W-1:0] fold1;
    logic [FOLD2_W-1:0] fold2;
    logic [FOLD3_W-1:0] fold3;
    coeff_t             reduced;

    // ==================================================
    // Stage 1: raw value for the mode
    // ==================================================

    always_comb begin
        case (mode_i)
            mode_pwm: raw_d = PROD_W'(a_i) * PROD_W'(b_i) + (acc_sel_i ? PROD_W'(c_i) : '0);
            // Adding Q first keeps the difference positive
            mode_pws: raw_d = PROD_W'(a_i) + PROD_W'(MLDSA_Q) - PROD_W'(b_i);
            default:  raw_d = PROD_W'(a_i) + PROD_W'(b_i);
        endcase
    end

    always_ff @(posedge clk) begin
        raw_q <= raw_d;
    end

    // ==================================================
    // Stage 2: reduction modulo Q
    // ==================================================

    // Each fold replaces hi*2^23 by hi*8191, three folds leave less than 2Q
    assign fold1 = FOLD1_W'(raw_q[PROD_W-1:COEFF_W]) * FOLD1_W'(FOLD_K)
                 + FOLD1_W'(raw_q[COEFF_W-1:0]);
    assign fold2 = FOLD2_W'(fold1[FOLD1_W-1:COEFF_W]) * FOLD2_W'(FOLD_K)
                 + FOLD2_W'(fold1[COEFF_W-1:0]);
    assign fold3 = FOLD3_W'(fold2[FOLD2_W-1:COEFF_W]) * FOLD3_W'(FOLD_K)
                 + FOLD3_W'(fold2[COEFF_W-1:0]);

    assign reduced = (fold3 >= FOLD3_W'(MLDSA_Q)) ? COEFF_W'(fold3 - FOLD3_W'(MLDSA_Q))
                                                  : fold3[COEFF_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
        end else begin
            res_o <= reduced;
        end
    end

endmodule

// File: logic/pwo_ctrl.sv
`timescale 1ns/1ps

module pwo_ctrl
    import pwo_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 15
)
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      start_i,
    input  logic                      accumulate_i,
    input  logic [MEM_ADDR_WIDTH-1:0] a_base_i,
    input  logic [MEM_ADDR_WIDTH-1:0] b_base_i,
    input  logic [MEM_ADDR_WIDTH-1:0] c_base_i,
    output logic                      a_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] a_rd_addr_o,
    output logic                      b_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] b_rd_addr_o,
    output logic                      c_rd_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] c_rd_addr_o,
    output logic                      wr_en_o,
    output logic [MEM_ADDR_WIDTH-1:0] wr_addr_o,
    output logic                      acc_sel_o,
    output logic                      busy_o,
    output logic                      done_o
);

    localparam logic [WORD_CNT_W-1:0] LAST_WORD = WORD_CNT_W'(POLY_WORDS - 1);

    logic                                  rd_active;
    logic [WORD_CNT_W-1:0]                 word_cnt;
    logic [PW_LATENCY-1:0]                 wr_en_dly;
    logic [PW_LATENCY-1:0][WORD_CNT_W-1:0] idx_dly;
    logic [1:0]                            c_rd_dly;
    logic [WORD_CNT_W-1:0]                 wr_idx;

    // ==================================================
    // Read side
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_active <= 1'b0;
            word_cnt  <= '0;
        end else if (start_i) begin
            rd_active <= 1'b1;
            word_cnt  <= '0;
        end else if (rd_active) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == LAST_WORD) begin
                rd_active <= 1'b0;
            end
        end
    end

    assign a_rd_en_o   = rd_active;
    assign b_rd_en_o   = rd_active;
    // Old c contents are only fetched for multiply-accumulate
    assign c_rd_en_o   = rd_active && accumulate_i;
    assign a_rd_addr_o = a_base_i + MEM_ADDR_WIDTH'(word_cnt);
    assign b_rd_addr_o = b_base_i + MEM_ADDR_WIDTH'(word_cnt);
    assign c_rd_addr_o = c_base_i + MEM_ADDR_WIDTH'(word_cnt);

    // ==================================================
    // Write side, aligned to the datapath
    // ==================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_dly <= '0;
            idx_dly   <= '0;
            c_rd_dly  <= '0;
            done_o    <= 1'b0;
        end else begin
            wr_en_dly <= {wr_en_dly[PW_LATENCY-2:0], rd_active};
            idx_dly   <= {idx_dly[PW_LATENCY-2:0], word_cnt};
            // Lines up with the c word in the datapath input register
            c_rd_dly  <= {c_rd_dly[0], c_rd_en_o};
            done_o    <= wr_en_o && (wr_idx == LAST_WORD);
        end
    end

    assign wr_idx    = idx_dly[PW_LATENCY-1];
    assign wr_en_o   = wr_en_dly[PW_LATENCY-1];
    assign wr_addr_o = c_base_i + MEM_ADDR_WIDTH'(wr_idx);
    assign acc_sel_o = c_rd_dly[1];

    // Busy covers the start cycle through the last write
    assign busy_o = start_i || rd_active || (|wr_en_dly);

endmodule

// File: logic/pwo_cfg_regs.sv
`timescale 1ns/1ps

module pwo_cfg_regs
    import pwo_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 15
)
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      busy_i,
    input  pwo_mode_t                 mode_i,
    input  logic                      accumulate_i,
    input  logic [MEM_ADDR_WIDTH-1:0] a_base_addr_i,
    input  logic [MEM_ADDR_WIDTH-1:0] b_base_addr_i,
    input  logic [MEM_ADDR_WIDTH-1:0] c_base_addr_i,
    output logic                      start_o,
    output pwo_mode_t                 mode_o,
    output logic                      accumulate_o,
    output logic [MEM_ADDR_WIDTH-1:0] a_base_o,
    output logic [MEM_ADDR_WIDTH-1:0] b_base_o,
    output logic [MEM_ADDR_WIDTH-1:0] c_base_o
);

    logic accept;

    // Enable is a level, only sampled while the engine is idle
    assign accept = enable_i && !busy_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_o      <= 1'b0;
            mode_o       <= mode_pwm;
            accumulate_o <= 1'b0;
            a_base_o     <= '0;
            b_base_o     <= '0;
            c_base_o     <= '0;
        end else begin
            start_o <= accept;
            if (accept) begin
                mode_o       <= mode_i;
                // Accumulate only means something for multiply
                accumulate_o <= accumulate_i && (mode_i == mode_pwm);
                a_base_o     <= a_base_addr_i;
                b_base_o     <= b_base_addr_i;
                c_base_o     <= c_base_addr_i;
            end
        end
    end

endmodule

// File: logic/pwo_pkg.sv
package pwo_pkg;

    // ==================================================
    // Coefficient and memory word geometry
    // ==================================================

    // One reduced coefficient
    localparam int COEFF_W = 23;

    // Coefficient plus one zero pad bit at the top
    localparam int SLOT_W = 24;

    localparam int LANES      = 4;
    localparam int MEM_DATA_W = LANES * SLOT_W;

    // 256 coefficients, four per word
    localparam int POLY_WORDS = 64;
    localparam int WORD_CNT_W = 6;

    // a*b + c before reduction
    localparam int PROD_W = 47;

    localparam logic [COEFF_W-1:0] MLDSA_Q = 23'd8380417;

    // Read strobe to write strobe of the same word
    localparam int PW_LATENCY = 4;

    // ==================================================
    // Types
    // ==================================================

    typedef enum logic [1:0] {
        mode_pwm = 2'd0,
        mode_pwa = 2'd1,
        mode_pws = 2'd2
    } pwo_mode_t;

    typedef logic [COEFF_W-1:0] coeff_t;

    // Slot 0 sits in the low bits of the word
    typedef logic [LANES-1:0][SLOT_W-1:0] mem_word_t;

endpackage
